// ==== logic/pong_pkg.sv ====
// Shared types for the pong core. Coordinates are 12 bits wide, so the
// total frame must stay below 4096 in both directions.
`default_nettype none

package pong_pkg;

    // screen coordinate or object position
    typedef logic [11:0] coord_t;

    // one colour channel
    typedef logic [7:0] colour_t;

    // game mode, IDLE lets both paddles track the ball
    typedef enum logic {
        IDLE = 1'b0,
        PLAY = 1'b1
    } game_state_t;

    localparam colour_t COLOUR_ON  = 8'hFF;  // lit pixel
    localparam colour_t COLOUR_OFF = 8'h00;  // background and blanking

endpackage

`default_nettype wire

// ==== logic/display_timings.sv ====
// Raster position counters and sync decode. Syncs are active low.
// The sync windows must lie within the blanking interval.
`default_nettype none
`timescale 1ns/10ps

module display_timings #(
    parameter int H_RES        = 1280,
    parameter int V_RES        = 720,
    parameter int H_TOTAL      = 1650,
    parameter int V_TOTAL      = 750,
    parameter int H_SYNC_START = 1390,
    parameter int H_SYNC_END   = 1430
) (
    input  wire logic      clk_pix,
    input  wire logic      reset,
    output pong_pkg::coord_t sx,
    output pong_pkg::coord_t sy,
    output logic           hsync,
    output logic           vsync,
    output logic           de,
    output logic           animate
);

    localparam pong_pkg::coord_t H_LAST = pong_pkg::coord_t'(H_TOTAL - 1);
    localparam pong_pkg::coord_t V_LAST = pong_pkg::coord_t'(V_TOTAL - 1);
    localparam pong_pkg::coord_t H_VIS  = pong_pkg::coord_t'(H_RES);
    localparam pong_pkg::coord_t V_VIS  = pong_pkg::coord_t'(V_RES);
    localparam pong_pkg::coord_t HS_STA = pong_pkg::coord_t'(H_SYNC_START);
    localparam pong_pkg::coord_t HS_END = pong_pkg::coord_t'(H_SYNC_END);
    localparam pong_pkg::coord_t H_TOT  = pong_pkg::coord_t'(H_TOTAL);

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_LAST) begin
            sx <= '0;
            sy <= (sy == V_LAST) ? '0 : sy + 1'b1;  // next line or new frame
        end else begin
            sx <= sx + 1'b1;
        end
    end

    always_comb begin
        hsync   = ~((sx >= HS_STA) && (sx < HS_END));
        vsync   = ~(sy == V_VIS);  // single sync line right after the picture
        de      = (sx < H_VIS) && (sy < V_VIS);
        animate = (sy == V_VIS) && (sx == '0);  // start of vertical blanking
    end

    a_sx_range: assert property (@(posedge clk_pix) disable iff (reset)
        sx < H_TOT)
        else $error("sx left its range");

endmodule

`default_nettype wire

// ==== logic/debounce.sv ====
// Button debouncer. The input is asynchronous; a change must hold for
// 2^DEB_BITS cycles after synchronization before the level follows it.
`default_nettype none
`timescale 1ns/10ps

module debounce #(
    parameter int DEB_BITS = 16
) (
    input  wire logic clk_pix,
    input  wire logic reset,
    input  wire logic in,
    output logic      level,
    output logic      released
);

    logic                sync_a;
    logic                sync_b;
    logic [DEB_BITS-1:0] cnt;  // stable cycles seen so far

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sync_a   <= 1'b0;
            sync_b   <= 1'b0;
            cnt      <= '0;
            level    <= 1'b0;
            released <= 1'b0;
        end else begin
            sync_a   <= in;
            sync_b   <= sync_a;
            released <= 1'b0;
            if (sync_b == level) begin
                cnt <= '0;  // bounce, start over
            end else if (&cnt) begin
                cnt      <= '0;
                level    <= sync_b;
                released <= level;  // old level high means falling edge
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/paddle_ctrl.sv ====
// One paddle. Moves only on the animate strobe, so the new position shows
// from the next frame. Needs P_SP < P_H and the paddle column on screen.
`default_nettype none
`timescale 1ns/10ps

module paddle_ctrl #(
    parameter int H_RES  = 1280,
    parameter int V_RES  = 720,
    parameter int P_H    = 80,
    parameter int P_W    = 15,
    parameter int P_SP   = 6,
    parameter int P_OFFS = 48,
    parameter int SIDE   = 0,  // 0 left column, 1 right column
    parameter int HUMAN  = 1   // buttons take over in PLAY
) (
    input  wire logic                  clk_pix,
    input  wire logic                  reset,
    input  wire logic                  animate,
    input  wire pong_pkg::game_state_t state,
    input  wire logic                  move_up,
    input  wire logic                  move_dn,
    input  wire pong_pkg::coord_t      ball_cy,
    input  wire pong_pkg::coord_t      sx,
    input  wire pong_pkg::coord_t      sy,
    output pong_pkg::coord_t           py,
    output logic                       draw
);

    localparam pong_pkg::coord_t PY_RST = pong_pkg::coord_t'((V_RES - P_H) / 2);
    localparam pong_pkg::coord_t PY_MIN = pong_pkg::coord_t'(P_SP);
    localparam pong_pkg::coord_t PY_MAX = pong_pkg::coord_t'(V_RES - P_H - P_SP);
    localparam pong_pkg::coord_t STEP   = pong_pkg::coord_t'(P_SP);
    localparam pong_pkg::coord_t SLACK  = pong_pkg::coord_t'(P_SP / 2);
    localparam pong_pkg::coord_t HALF_H = pong_pkg::coord_t'(P_H / 2);
    localparam pong_pkg::coord_t HEIGHT = pong_pkg::coord_t'(P_H);
    localparam pong_pkg::coord_t V_VIS  = pong_pkg::coord_t'(V_RES);
    localparam pong_pkg::coord_t COL_L  = (SIDE != 0) ?
        pong_pkg::coord_t'(H_RES - P_OFFS - P_W) : pong_pkg::coord_t'(P_OFFS);
    localparam pong_pkg::coord_t COL_R  = COL_L + pong_pkg::coord_t'(P_W);

    logic             human;
    pong_pkg::coord_t pcy;  // paddle centre

    assign human = (HUMAN != 0) && (state == pong_pkg::PLAY);
    assign pcy   = py + HALF_H;

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            py <= PY_RST;
        end else if (animate) begin
            if (human) begin
                if (move_up) begin
                    if (py > PY_MIN) py <= py - STEP;
                end else if (move_dn) begin
                    if (py < PY_MAX) py <= py + STEP;
                end
            end else if (pcy + SLACK < ball_cy) begin  // ball below
                if (py < PY_MAX) py <= py + STEP;
            end else if (pcy > ball_cy + SLACK) begin  // ball above
                if (py > PY_MIN) py <= py - STEP;
            end
        end
    end

    assign draw = (sx >= COL_L) && (sx < COL_R) && (sy >= py) && (sy < py + HEIGHT);

    a_paddle_on_screen: assert property (@(posedge clk_pix) disable iff (reset)
        animate |=> (py + HEIGHT <= V_VIS))
        else $error("paddle moved past the bottom of the screen");

endmodule

`default_nettype wire

// ==== logic/ball_ctrl.sv ====
// Square ball with edge and paddle bounce, updated once per frame.
// Collisions are seen while the frame is drawn and act at the next animate.
`default_nettype none
`timescale 1ns/10ps

module ball_ctrl #(
    parameter int H_RES  = 1280,
    parameter int V_RES  = 720,
    parameter int B_SIZE = 16,
    parameter int B_SPX  = 10,
    parameter int B_SPY  = 6
) (
    input  wire logic             clk_pix,
    input  wire logic             reset,
    input  wire logic             animate,
    input  wire pong_pkg::coord_t sx,
    input  wire pong_pkg::coord_t sy,
    input  wire logic             p1_draw,
    input  wire logic             p2_draw,
    output pong_pkg::coord_t      ball_cy,
    output logic                  draw
);

    localparam pong_pkg::coord_t BX_RST = pong_pkg::coord_t'((H_RES - B_SIZE) / 2);
    localparam pong_pkg::coord_t BY_RST = pong_pkg::coord_t'((V_RES - B_SIZE) / 2);
    localparam pong_pkg::coord_t SPX    = pong_pkg::coord_t'(B_SPX);
    localparam pong_pkg::coord_t SPY    = pong_pkg::coord_t'(B_SPY);
    localparam pong_pkg::coord_t SIZE   = pong_pkg::coord_t'(B_SIZE);
    localparam pong_pkg::coord_t X_EDGE = pong_pkg::coord_t'(H_RES - (B_SPX + B_SIZE));
    localparam pong_pkg::coord_t Y_EDGE = pong_pkg::coord_t'(V_RES - (B_SPY + B_SIZE));
    localparam pong_pkg::coord_t H_VIS  = pong_pkg::coord_t'(H_RES);
    localparam pong_pkg::coord_t V_VIS  = pong_pkg::coord_t'(V_RES);

    pong_pkg::coord_t bx;
    pong_pkg::coord_t by;
    logic             dx;  // 1 moves left
    logic             dy;  // 1 moves up
    logic             p1_col;
    logic             p2_col;

    // collision latches, live for one frame
    always_ff @(posedge clk_pix) begin
        if (reset || animate) begin
            p1_col <= 1'b0;
            p2_col <= 1'b0;
        end else if (draw) begin
            if (p1_draw) p1_col <= 1'b1;
            if (p2_draw) p2_col <= 1'b1;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            bx <= BX_RST;
            by <= BY_RST;
            dx <= 1'b0;
            dy <= 1'b0;
        end else if (animate) begin
            if (p1_col) begin  // left paddle sends it right
                dx <= 1'b0;
                bx <= bx + SPX;
            end else if (p2_col) begin
                dx <= 1'b1;
                bx <= bx - SPX;
            end else if (bx >= X_EDGE) begin  // right edge
                dx <= 1'b1;
                bx <= bx - SPX;
            end else if (bx < SPX) begin  // left edge
                dx <= 1'b0;
                bx <= bx + SPX;
            end else begin
                bx <= dx ? bx - SPX : bx + SPX;
            end

            if (by >= Y_EDGE) begin  // bottom edge
                dy <= 1'b1;
                by <= by - SPY;
            end else if (by < SPY) begin  // top edge
                dy <= 1'b0;
                by <= by + SPY;
            end else begin
                by <= dy ? by - SPY : by + SPY;
            end
        end
    end

    assign ball_cy = by + (SIZE >> 1);
    assign draw    = (sx >= bx) && (sx < bx + SIZE) && (sy >= by) && (sy < by + SIZE);

    a_ball_visible: assert property (@(posedge clk_pix) disable iff (reset)
        animate |=> (bx + SIZE <= H_VIS) && (by + SIZE <= V_VIS))
        else $error("ball left the visible area");

endmodule

`default_nettype wire

// ==== logic/pong_top.sv ====
// Pong core up to parallel video; a DVI or TMDS stage attaches to the outputs.
// Buttons are raw levels, video is delayed one cycle from the raster counters.
`default_nettype none
`timescale 1ns/10ps

module pong_top #(
    parameter int H_RES        = 1280,
    parameter int V_RES        = 720,
    parameter int H_TOTAL      = 1650,
    parameter int V_TOTAL      = 750,
    parameter int H_SYNC_START = 1390,
    parameter int H_SYNC_END   = 1430,
    parameter int B_SIZE       = 16,
    parameter int B_SPX        = 10,
    parameter int B_SPY        = 6,
    parameter int P_H          = 80,
    parameter int P_W          = 15,
    parameter int P_SP         = 6,
    parameter int P_OFFS       = 48,
    parameter int DEB_BITS     = 16
) (
    input  wire logic          clk_pix,
    input  wire logic          reset,
    input  wire logic          btn_ctrl,
    input  wire logic          btn_up,
    input  wire logic          btn_dn,
    output logic               hsync,
    output logic               vsync,
    output logic               de,
    output pong_pkg::colour_t  red,
    output pong_pkg::colour_t  green,
    output pong_pkg::colour_t  blue
);

    pong_pkg::coord_t      sx;
    pong_pkg::coord_t      sy;
    logic                  t_hsync;
    logic                  t_vsync;
    logic                  t_de;
    logic                  animate;
    logic                  ctrl_release;
    logic                  move_up;
    logic                  move_dn;
    pong_pkg::game_state_t state;
    pong_pkg::game_state_t state_next;
    pong_pkg::coord_t      ball_cy;
    logic                  p1_draw;
    logic                  p2_draw;
    logic                  b_draw;
    logic                  lit;

    display_timings #(
        .H_RES(H_RES), .V_RES(V_RES), .H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL),
        .H_SYNC_START(H_SYNC_START), .H_SYNC_END(H_SYNC_END)
    ) u_display_timings (
        .clk_pix, .reset, .sx, .sy,
        .hsync(t_hsync), .vsync(t_vsync), .de(t_de), .animate
    );

    debounce #(.DEB_BITS(DEB_BITS)) u_deb_ctrl (
        .clk_pix, .reset, .in(btn_ctrl), .level(), .released(ctrl_release)
    );

    debounce #(.DEB_BITS(DEB_BITS)) u_deb_up (
        .clk_pix, .reset, .in(btn_up), .level(move_up), .released()
    );

    debounce #(.DEB_BITS(DEB_BITS)) u_deb_dn (
        .clk_pix, .reset, .in(btn_dn), .level(move_dn), .released()
    );

    // ctrl release flips the mode
    always_comb begin
        case (state)
            pong_pkg::IDLE: state_next = ctrl_release ? pong_pkg::PLAY : pong_pkg::IDLE;
            pong_pkg::PLAY: state_next = ctrl_release ? pong_pkg::IDLE : pong_pkg::PLAY;
            default:        state_next = pong_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_pix) begin
        if (reset) state <= pong_pkg::IDLE;
        else       state <= state_next;
    end

    paddle_ctrl #(
        .H_RES(H_RES), .V_RES(V_RES), .P_H(P_H), .P_W(P_W), .P_SP(P_SP),
        .P_OFFS(P_OFFS), .SIDE(0), .HUMAN(1)
    ) u_paddle_1 (
        .clk_pix, .reset, .animate, .state, .move_up, .move_dn,
        .ball_cy, .sx, .sy, .py(), .draw(p1_draw)
    );

    paddle_ctrl #(
        .H_RES(H_RES), .V_RES(V_RES), .P_H(P_H), .P_W(P_W), .P_SP(P_SP),
        .P_OFFS(P_OFFS), .SIDE(1), .HUMAN(0)
    ) u_paddle_2 (
        .clk_pix, .reset, .animate, .state, .move_up(1'b0), .move_dn(1'b0),
        .ball_cy, .sx, .sy, .py(), .draw(p2_draw)
    );

    ball_ctrl #(
        .H_RES(H_RES), .V_RES(V_RES), .B_SIZE(B_SIZE), .B_SPX(B_SPX), .B_SPY(B_SPY)
    ) u_ball (
        .clk_pix, .reset, .animate, .sx, .sy,
        .p1_draw, .p2_draw, .ball_cy, .draw(b_draw)
    );

    assign lit = t_de && (b_draw || p1_draw || p2_draw);

    // pixel stage, syncs travel with the colour
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b0;
            red   <= pong_pkg::COLOUR_OFF;
            green <= pong_pkg::COLOUR_OFF;
            blue  <= pong_pkg::COLOUR_OFF;
        end else begin
            hsync <= t_hsync;
            vsync <= t_vsync;
            de    <= t_de;
            red   <= lit ? pong_pkg::COLOUR_ON : pong_pkg::COLOUR_OFF;
            green <= lit ? pong_pkg::COLOUR_ON : pong_pkg::COLOUR_OFF;
            blue  <= lit ? pong_pkg::COLOUR_ON : pong_pkg::COLOUR_OFF;
        end
    end

endmodule

`default_nettype wire

// ==== tests/clock_gen.sv ====
// Testbench clock and reset source. Reset is released 10 ns after the
// last rising edge of the reset window.
`default_nettype none
`timescale 1ns/10ps

module clock_gen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 8
) (
    output logic clk_pix,
    output logic reset
);

    initial begin
        clk_pix = 1'b0;
        forever #(PERIOD / 2) clk_pix = ~clk_pix;
    end

    initial begin
        reset = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_pix);
        #10 reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== tests/tb_pong.sv ====
// Small screen testbench: rebuilds each frame from the video stream and checks
// timing, blanking, object sizes and paddle 1 motion against a per-frame model.
// Stimulus changes right after a frame ends, so it settles long before animate.
`default_nettype none
`timescale 1ns/10ps

module tb_pong;

    localparam int H_RES = 64, V_RES = 48, H_TOTAL = 80, V_TOTAL = 56;
    localparam int B_SIZE = 4, P_H = 12, P_W = 3, P_SP = 2, P_OFFS = 6, DEB_BITS = 3;
    localparam int P1_COL = P_OFFS;
    localparam int P2_COL = H_RES - P_OFFS - P_W;
    localparam int DRIVE_DLY = 10;
    localparam int HOLD_MIN = 2 * (2 + 2 ** DEB_BITS);  // well above debounce time
    localparam int ROWS = 8;

    typedef enum int {TRACK, STILL, UP, DOWN} motion_t;

    // per row: ctrl press, up level, down level, frames held, expected paddle 1 motion
    bit      tbl_ctrl   [ROWS] = '{0, 0, 1, 0, 0, 0, 1, 0};
    bit      tbl_up     [ROWS] = '{0, 1, 0, 1, 0, 0, 0, 0};
    bit      tbl_dn     [ROWS] = '{0, 0, 0, 0, 1, 0, 1, 0};
    int      tbl_frames [ROWS] = '{3, 3, 2, 16, 18, 2, 4, 6};
    motion_t tbl_motion [ROWS] = '{TRACK, TRACK, STILL, UP, DOWN, STILL, TRACK, TRACK};

    logic clk_pix, reset, btn_ctrl, btn_up, btn_dn, hsync, vsync, de;
    logic [7:0] red, green, blue;

    int      errors = 0, frame = 0, row = -1, col = 0, cyc = 0, rise_cyc = 0;
    int      lit_total = 0, b_rmin = V_RES, b_rmax = -1, b_cmin = H_RES, b_cmax = -1;
    int      model_py = (V_RES - P_H) / 2;  // paddle 1 top after reset
    int      p1_cnt [V_RES];
    int      p2_cnt [V_RES];
    motion_t cur_motion = TRACK;             // IDLE after reset
    bit      rst_q = 1'b1, de_q = 1'b0, vsync_q = 1'b1;
    event    frame_done;

    clock_gen #(.PERIOD(100), .RST_CYCLES(8)) u_clock_gen (.clk_pix, .reset);

    pong_top #(
        .H_RES(H_RES), .V_RES(V_RES), .H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL),
        .H_SYNC_START(68), .H_SYNC_END(72), .B_SIZE(B_SIZE), .B_SPX(2), .B_SPY(2),
        .P_H(P_H), .P_W(P_W), .P_SP(P_SP), .P_OFFS(P_OFFS), .DEB_BITS(DEB_BITS)
    ) u_pong_top (
        .clk_pix, .reset, .btn_ctrl, .btn_up, .btn_dn,
        .hsync, .vsync, .de, .red, .green, .blue
    );

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // next paddle 1 top from the rule the current row expects
    task automatic advance_model(input int cy);
        int pcy;
        pcy = model_py + P_H / 2;
        case (cur_motion)
            UP:    if (model_py > P_SP) model_py -= P_SP;
            DOWN:  if (model_py < V_RES - P_H - P_SP) model_py += P_SP;
            TRACK: begin
                if (pcy + P_SP / 2 < cy && model_py < V_RES - P_H - P_SP) begin
                    model_py += P_SP;
                end else if (pcy > cy + P_SP / 2 && model_py > P_SP) begin
                    model_py -= P_SP;
                end
            end
            default: ;
        endcase
    endtask

    task automatic close_frame();
        int r, p1_top, p1_bot, p2_top, p2_bot;
        p1_top = -1;
        p2_top = -1;
        p1_bot = -1;
        p2_bot = -1;
        for (r = 0; r < V_RES; r++) begin
            if (p1_cnt[r] == P_W && p1_top < 0) p1_top = r;
            if (p1_cnt[r] == P_W) p1_bot = r;
            if (p2_cnt[r] == P_W && p2_top < 0) p2_top = r;
            if (p2_cnt[r] == P_W) p2_bot = r;
        end
        expect_eq("de lines per frame", row + 1, V_RES);
        if (frame > 0) begin
            expect_eq("ball rows", b_rmax - b_rmin + 1, B_SIZE);
            if (b_cmax - b_cmin + 1 == B_SIZE) begin  // ball clear of paddle columns
                expect_eq("lit pixels per frame", lit_total, B_SIZE * B_SIZE + 2 * P_W * P_H);
                expect_eq("paddle 1 rows", p1_bot - p1_top + 1, P_H);
                expect_eq("paddle 2 rows", p2_bot - p2_top + 1, P_H);
                expect_eq("paddle 1 top", p1_top, model_py);
            end
        end
        advance_model(b_rmin + B_SIZE / 2);
        frame++;
        row = -1;
        lit_total = 0;
        b_rmin = V_RES;
        b_rmax = -1;
        b_cmin = H_RES;
        b_cmax = -1;
        for (r = 0; r < V_RES; r++) begin
            p1_cnt[r] = 0;
            p2_cnt[r] = 0;
        end
        -> frame_done;
    endtask

    // output monitor, samples away from the active edge
    always @(negedge clk_pix) begin
        if (reset || rst_q) begin
            expect_eq("de/hsync/vsync/rgb at reset", {de, hsync, vsync, red, green, blue},
                      {3'b011, 24'h0});
        end else begin
            cyc++;
            if (de) begin
                if (!de_q) begin
                    if (row >= 0) expect_eq("de rise spacing", cyc - rise_cyc, H_TOTAL);
                    rise_cyc = cyc;
                    row++;
                    col = 0;
                end
                if ({red, green, blue} != 24'h0) begin
                    expect_eq("rgb on lit pixel", {red, green, blue}, 24'hFFFFFF);
                    lit_total++;
                    if (col >= P1_COL && col < P1_COL + P_W) begin
                        p1_cnt[row]++;
                    end else if (col >= P2_COL && col < P2_COL + P_W) begin
                        p2_cnt[row]++;
                    end else begin  // ball pixel
                        b_rmin = (row < b_rmin) ? row : b_rmin;
                        b_rmax = (row > b_rmax) ? row : b_rmax;
                        b_cmin = (col < b_cmin) ? col : b_cmin;
                        b_cmax = (col > b_cmax) ? col : b_cmax;
                    end
                end
                col++;
            end else begin
                if (de_q) expect_eq("de high cycles per line", col, H_RES);
                expect_eq("rgb in blanking", {red, green, blue}, 24'h0);
            end
            if (!vsync && vsync_q) close_frame();
        end
        rst_q = reset;
        de_q = de;
        vsync_q = vsync;
    end

    initial begin
        int i, hold;
        btn_ctrl = 1'b0;
        btn_up = 1'b0;
        btn_dn = 1'b0;
        hold = $urandom(32'h52ad);  // seed once
        @(frame_done);
        for (i = 0; i < ROWS; i++) begin
            @(posedge clk_pix);
            #DRIVE_DLY;
            btn_up = tbl_up[i];
            btn_dn = tbl_dn[i];
            cur_motion = tbl_motion[i];  // applies at this frame's animate
            if (tbl_ctrl[i]) begin
                hold = HOLD_MIN + $urandom_range(40);
                btn_ctrl = 1'b1;
                repeat (hold) @(posedge clk_pix);
                #DRIVE_DLY btn_ctrl = 1'b0;
            end
            repeat (tbl_frames[i]) @(frame_done);
        end
        $display("frames checked: %0d, errors: %0d", frame, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // watchdog, table length plus ten frames of margin
    initial begin
        int k, total;
        total = 10;
        for (k = 0; k < ROWS; k++) total += tbl_frames[k];
        repeat (total * H_TOTAL * V_TOTAL) @(posedge clk_pix);
        $display("watchdog expired, the stimulus table did not finish in %0d frames", total);
        $display("frames checked: %0d, errors: %0d", frame, errors);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== pong.f ====
logic/pong_pkg.sv
logic/display_timings.sv
logic/debounce.sv
logic/paddle_ctrl.sv
logic/ball_ctrl.sv
logic/pong_top.sv
tests/clock_gen.sv
tests/tb_pong.sv

// ==== Makefile ====
SRCS := $(wildcard logic/*.sv tests/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_pong
	@out=$$(./obj_dir/Vtb_pong); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

obj_dir/Vtb_pong: pong.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
		--top-module tb_pong -f pong.f

clean:
	rm -rf obj_dir
